//--- verilog/csi2_config.svh
`ifndef CSI2_CONFIG_SVH
`define CSI2_CONFIG_SVH

//////////////////////////////
// Word FIFO
//////////////////////////////

// Number of entries, power of two
`define CSI2_FIFO_DEPTH 8

//////////////////////////////
// Header ECC
//////////////////////////////

// Syndrome does not point at a single data bit
`define CSI2_NO_POS 31

`endif

//--- verilog/csi2_types_pkg.sv
package csi2_types_pkg;

// One byte from the lane
typedef logic [7 : 0]  csi2_byte_t;

// Packed word; for a header, 23..0 are data id and word count,
// 29..24 the ECC and 31..30 unused
typedef logic [31 : 0] csi2_word_t;

// Received ECC xor regenerated parity
typedef logic [5 : 0]  csi2_syndrome_t;

// Bit to flip in 23..0, or the no-correction marker
typedef logic [4 : 0]  csi2_bit_pos_t;

// Byte lane of the next byte, then a full word waiting for the FIFO
typedef enum logic [2 : 0] {
  PACK_BYTE0,
  PACK_BYTE1,
  PACK_BYTE2,
  PACK_BYTE3,
  PACK_HOLD
} csi2_pack_state_e;

endpackage

//--- verilog/csi2_ecc_pkg.sv
`include "csi2_config.svh"

package csi2_ecc_pkg;

import csi2_types_pkg::*;

//////////////////////////////
// Parity masks over bits 23..0
//////////////////////////////

// Index k selects the data bits that feed parity bit k
parameter logic [5 : 0][23 : 0] CSI2_ECC_MASK = {
  24'hEFFC00,
  24'hDF03F0,
  24'hB8E38E,
  24'h749A6D,
  24'hF2555B,
  24'hF12CB7
};

// Position of the single data bit whose parity column equals the syndrome
function automatic csi2_bit_pos_t csi2_ecc_pos( csi2_syndrome_t syn );
  csi2_bit_pos_t  pos;
  csi2_syndrome_t col;
  pos = csi2_bit_pos_t'( `CSI2_NO_POS );
  col = '0;
  for( int i = 0; i < 24; i++ )
    begin
      for( int k = 0; k < 6; k++ )
        col[k] = CSI2_ECC_MASK[k][i];
      // Columns are all nonzero and distinct, so zero never matches
      if( col == syn )
        pos = csi2_bit_pos_t'( i );
    end
  return pos;
endfunction

endpackage

//--- verilog/csi2_word_if.sv
`timescale 1ns/1ns

interface csi2_word_if
  import csi2_types_pkg::*;
();

logic       valid;
logic       ready;
csi2_word_t data;
logic       last;

modport src (
  output valid,
  output data,
  output last,
  input  ready
);

modport dst (
  input  valid,
  input  data,
  input  last,
  output ready
);

endinterface

//--- verilog/csi2_byte_packer.sv
`timescale 1ns/1ns

module csi2_byte_packer
  import csi2_types_pkg::*;
(
  input                clk_i,
  input                srst_i,
  input                byte_valid_i,
  input  csi2_byte_t   byte_i,
  input                byte_last_i,
  output logic         byte_ready_o,
  csi2_word_if.src     word_if
);

csi2_pack_state_e state;
csi2_word_t       word_q;
logic             last_q;
logic             run_q;
logic             byte_acc;

// No bytes while a full word waits for the FIFO
assign byte_ready_o = run_q && ( state != PACK_HOLD );
assign byte_acc     = byte_valid_i && byte_ready_o;

assign word_if.valid = ( state == PACK_HOLD );
assign word_if.data  = word_q;
assign word_if.last  = last_q;

// Input opens one cycle after reset
always_ff @( posedge clk_i )
  if( srst_i )
    run_q <= 1'b0;
  else
    run_q <= 1'b1;

always_ff @( posedge clk_i )
  if( srst_i )
    state <= PACK_BYTE0;
  else
    case( state )
      PACK_BYTE0:
        if( byte_acc )
          state <= PACK_BYTE1;
      PACK_BYTE1:
        if( byte_acc )
          state <= PACK_BYTE2;
      PACK_BYTE2:
        if( byte_acc )
          state <= PACK_BYTE3;
      PACK_BYTE3:
        if( byte_acc )
          state <= PACK_HOLD;
      PACK_HOLD:
        if( word_if.ready )
          state <= PACK_BYTE0;
      default:
        state <= PACK_BYTE0;
    endcase

// Little-endian, first byte lands in 7..0
always_ff @( posedge clk_i )
  if( byte_acc )
    case( state )
      PACK_BYTE0: word_q[7 : 0]   <= byte_i;
      PACK_BYTE1: word_q[15 : 8]  <= byte_i;
      PACK_BYTE2: word_q[23 : 16] <= byte_i;
      PACK_BYTE3:
        begin
          word_q[31 : 24] <= byte_i;
          last_q          <= byte_last_i;
        end
      default: ;
    endcase

// Packets are whole words
a_last_on_byte3: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  byte_acc && byte_last_i |-> state == PACK_BYTE3 );

endmodule

//--- verilog/csi2_word_fifo.sv
`timescale 1ns/1ns

`include "csi2_config.svh"

module csi2_word_fifo
  import csi2_types_pkg::*;
(
  input            clk_i,
  input            srst_i,
  csi2_word_if.dst in_if,
  csi2_word_if.src out_if
);

localparam int DEPTH  = `CSI2_FIFO_DEPTH;
localparam int ADDR_W = $clog2( DEPTH );

csi2_word_t        mem_data [DEPTH];
logic              mem_last [DEPTH];
logic [ADDR_W : 0] wr_ptr;
logic [ADDR_W : 0] rd_ptr;
logic [ADDR_W : 0] level;
logic              full;
logic              empty;
logic              wr_en;
logic              rd_en;

// Extra pointer bit tells full from empty
assign level = wr_ptr - rd_ptr;
assign full  = ( wr_ptr[ADDR_W] != rd_ptr[ADDR_W] ) &&
               ( wr_ptr[ADDR_W - 1 : 0] == rd_ptr[ADDR_W - 1 : 0] );
assign empty = ( wr_ptr == rd_ptr );

assign in_if.ready = !full;
assign wr_en       = in_if.valid && !full;

// Show-ahead, head entry is always on the output
assign out_if.valid = !empty;
assign out_if.data  = mem_data[rd_ptr[ADDR_W - 1 : 0]];
assign out_if.last  = mem_last[rd_ptr[ADDR_W - 1 : 0]];
assign rd_en        = out_if.ready && !empty;

always_ff @( posedge clk_i )
  if( wr_en )
    begin
      mem_data[wr_ptr[ADDR_W - 1 : 0]] <= in_if.data;
      mem_last[wr_ptr[ADDR_W - 1 : 0]] <= in_if.last;
    end

always_ff @( posedge clk_i )
  if( srst_i )
    wr_ptr <= '0;
  else
    if( wr_en )
      wr_ptr <= wr_ptr + 1'b1;

always_ff @( posedge clk_i )
  if( srst_i )
    rd_ptr <= '0;
  else
    if( rd_en )
      rd_ptr <= rd_ptr + 1'b1;

// Overflow or underflow would push the level out of range
a_level: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  level <= ( ADDR_W + 1 )'( DEPTH ) );

// A stalled head entry stays put until it is taken
a_head_stable: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  out_if.valid && !out_if.ready |=>
    out_if.valid && $stable( out_if.data ) && $stable( out_if.last ) );

endmodule

//--- verilog/csi2_syndrome_rom.sv
`timescale 1ns/1ns

module csi2_syndrome_rom
  import csi2_types_pkg::*;
  import csi2_ecc_pkg::*;
(
  input                 clk_i,
  input csi2_syndrome_t addr_i,
  output csi2_bit_pos_t pos_o
);

typedef csi2_bit_pos_t [63 : 0] rom_table_t;

function automatic rom_table_t build_table();
  rom_table_t tbl;
  for( int a = 0; a < 64; a++ )
    tbl[a] = csi2_ecc_pos( csi2_syndrome_t'( a ) );
  return tbl;
endfunction

// Table is fixed at elaboration
localparam rom_table_t ROM_TABLE = build_table();

always_ff @( posedge clk_i )
  pos_o <= ROM_TABLE[addr_i];

endmodule

//--- verilog/csi2_header_dec.sv
`timescale 1ns/1ns

`include "csi2_config.svh"

module csi2_header_dec
  import csi2_types_pkg::*;
  import csi2_ecc_pkg::*;
(
  input                    clk_i,
  input                    srst_i,
  csi2_word_if.dst         word_if,
  output logic             out_valid_o,
  input                    out_ready_i,
  output csi2_word_t       out_word_o,
  output logic             out_last_o,
  output logic             out_hdr_o,
  output logic             hdr_error_o,
  output logic             hdr_corrected_o
);

localparam csi2_bit_pos_t NO_POS = csi2_bit_pos_t'( `CSI2_NO_POS );

logic           advance;
logic           pop;
logic           sop_q;
csi2_syndrome_t in_parity;
csi2_syndrome_t in_syn;
csi2_syndrome_t rom_addr;
csi2_bit_pos_t  rom_pos;

logic           s1_valid;
csi2_word_t     s1_word;
logic           s1_last;
logic           s1_hdr;
csi2_syndrome_t s1_syn;

logic           s1_err;
logic           fix_en;
csi2_word_t     fix_word;

// Pipeline moves when the output stage is free or being taken
assign advance       = !out_valid_o || out_ready_i;
assign word_if.ready = advance;
assign pop           = word_if.valid && advance;

//////////////////////////////
// Syndrome
//////////////////////////////

always_comb
  for( int k = 0; k < 6; k++ )
    in_parity[k] = ^( word_if.data[23 : 0] & CSI2_ECC_MASK[k] );

assign in_syn = in_parity ^ word_if.data[29 : 24];

// On a stall the ROM keeps looking up the held stage-1 syndrome
assign rom_addr = advance ? in_syn : s1_syn;

csi2_syndrome_rom i_syndrome_rom (
  .clk_i  ( clk_i    ),
  .addr_i ( rom_addr ),
  .pos_o  ( rom_pos  )
);

// Next word opens a packet
always_ff @( posedge clk_i )
  if( srst_i )
    sop_q <= 1'b1;
  else
    if( pop )
      sop_q <= word_if.last;

//////////////////////////////
// Stage 1
//////////////////////////////

always_ff @( posedge clk_i )
  if( srst_i )
    s1_valid <= 1'b0;
  else
    if( advance )
      s1_valid <= word_if.valid;

always_ff @( posedge clk_i )
  if( pop )
    begin
      s1_word <= word_if.data;
      s1_last <= word_if.last;
      s1_hdr  <= sop_q;
      s1_syn  <= in_syn;
    end

//////////////////////////////
// Stage 2
//////////////////////////////

always_comb
  begin
    s1_err   = s1_valid && s1_hdr && ( s1_syn != '0 );
    fix_en   = s1_err && ( rom_pos != NO_POS );
    fix_word = s1_word;
    // ROM only gives 0..23 besides the marker
    if( fix_en )
      fix_word[rom_pos] = ~s1_word[rom_pos];
  end

always_ff @( posedge clk_i )
  if( srst_i )
    begin
      out_valid_o     <= 1'b0;
      out_hdr_o       <= 1'b0;
      hdr_error_o     <= 1'b0;
      hdr_corrected_o <= 1'b0;
    end
  else
    if( advance )
      begin
        out_valid_o     <= s1_valid;
        out_hdr_o       <= s1_valid && s1_hdr;
        hdr_error_o     <= s1_err;
        hdr_corrected_o <= fix_en;
      end

always_ff @( posedge clk_i )
  if( advance && s1_valid )
    begin
      out_word_o <= fix_word;
      out_last_o <= s1_last;
    end

a_corr_is_hdr_err: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  out_valid_o && hdr_corrected_o |-> hdr_error_o && out_hdr_o );

endmodule

//--- verilog/csi2_header_rx.sv
`timescale 1ns/1ns

module csi2_header_rx
  import csi2_types_pkg::*;
(
  input                clk_i,
  input                srst_i,

  // Lane bytes
  input                byte_valid_i,
  input  csi2_byte_t   byte_i,
  input                byte_last_i,
  output logic         byte_ready_o,

  // Words out, header checked
  output logic         word_valid_o,
  output csi2_word_t   word_o,
  output logic         word_last_o,
  output logic         hdr_o,
  output logic         hdr_error_o,
  output logic         hdr_corrected_o,
  input                word_ready_i
);

csi2_word_if pack_if ();
csi2_word_if fifo_if ();

csi2_byte_packer i_byte_packer (
  .clk_i        ( clk_i        ),
  .srst_i       ( srst_i       ),
  .byte_valid_i ( byte_valid_i ),
  .byte_i       ( byte_i       ),
  .byte_last_i  ( byte_last_i  ),
  .byte_ready_o ( byte_ready_o ),
  .word_if      ( pack_if      )
);

csi2_word_fifo i_word_fifo (
  .clk_i  ( clk_i   ),
  .srst_i ( srst_i  ),
  .in_if  ( pack_if ),
  .out_if ( fifo_if )
);

csi2_header_dec i_header_dec (
  .clk_i           ( clk_i           ),
  .srst_i          ( srst_i          ),
  .word_if         ( fifo_if         ),
  .out_valid_o     ( word_valid_o    ),
  .out_ready_i     ( word_ready_i    ),
  .out_word_o      ( word_o          ),
  .out_last_o      ( word_last_o     ),
  .out_hdr_o       ( hdr_o           ),
  .hdr_error_o     ( hdr_error_o     ),
  .hdr_corrected_o ( hdr_corrected_o )
);

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int HALF_PERIOD = 2
)(
  output logic clk_o
);

// 4 ns period
initial
  begin
    clk_o = 1'b0;
    forever
      #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

//--- sim/tb_csi2_header_rx.sv
`timescale 1ns/1ns

module tb_csi2_header_rx
  import csi2_types_pkg::*;
  import csi2_ecc_pkg::*;
();

localparam int PASSES     = 4;
localparam int BYTE_LIMIT = 300;
localparam int WORD_LIMIT = 600;
localparam int RUN_LIMIT  = 50000;
localparam int LONG_STALL = 64;

typedef struct packed {
  csi2_byte_t data;
  logic       last;
} lane_byte_t;

typedef struct packed {
  csi2_word_t word;
  logic       last;
  logic       hdr;
  logic       err;
  logic       corr;
} exp_word_t;

logic       clk_i;
logic       srst_i;
logic       byte_valid_i;
csi2_byte_t byte_i;
logic       byte_last_i;
logic       byte_ready_o;
logic       word_valid_o;
csi2_word_t word_o;
logic       word_last_o;
logic       hdr_o;
logic       hdr_error_o;
logic       hdr_corrected_o;
logic       word_ready_i;

lane_byte_t byte_q [$];
exp_word_t  exp_q [$];
int         seed = 47811;
logic       rx_done;
logic       fill_seen;

tb_clock_gen i_clock_gen (
  .clk_o ( clk_i )
);

csi2_header_rx i_csi2_header_rx (
  .clk_i           ( clk_i           ),
  .srst_i          ( srst_i          ),
  .byte_valid_i    ( byte_valid_i    ),
  .byte_i          ( byte_i          ),
  .byte_last_i     ( byte_last_i     ),
  .byte_ready_o    ( byte_ready_o    ),
  .word_valid_o    ( word_valid_o    ),
  .word_o          ( word_o          ),
  .word_last_o     ( word_last_o     ),
  .hdr_o           ( hdr_o           ),
  .hdr_error_o     ( hdr_error_o     ),
  .hdr_corrected_o ( hdr_corrected_o ),
  .word_ready_i    ( word_ready_i    )
);

task automatic abort_run( input string why );
  $display( "sim failed" );
  $fatal( 1, "%s", why );
endtask

task automatic check_word( input string name, input csi2_word_t got, input csi2_word_t exp );
  if( got !== exp )
    begin
      $display( "** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp );
      abort_run( "output word mismatch" );
    end
endtask

task automatic check_flag( input string name, input logic got, input logic exp );
  if( got !== exp )
    begin
      $display( "** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp );
      abort_run( "output flag mismatch" );
    end
endtask

// CSI-2 parity of a header, one bit per mask
function automatic csi2_syndrome_t header_ecc( input logic [23 : 0] data );
  csi2_syndrome_t ecc;
  for( int k = 0; k < 6; k++ )
    ecc[k] = ^( data & CSI2_ECC_MASK[k] );
  return ecc;
endfunction

// Lane order is little-endian
task automatic push_word( input csi2_word_t word, input logic last );
  for( int k = 0; k < 4; k++ )
    byte_q.push_back( lane_byte_t'{ word[8 * k +: 8], last && ( k == 3 ) } );
endtask

//////////////////////////////
// Test data
//////////////////////////////

task automatic load_testdata();
  int               fd;
  int               code;
  int               n_words;
  int               n_bytes;
  int               n_exp;
  logic [23 : 0]    tok;
  logic [1279 : 0]  note;
  logic [23 : 0]    hdr24;
  csi2_word_t       flip;
  csi2_word_t       residual;
  csi2_word_t       clean;
  logic             err;
  logic             corr;
  csi2_byte_t       b [4];
  fd = $fopen( "sim/csi2_testdata.txt", "r" );
  if( fd == 0 )
    abort_run( "cannot open sim/csi2_testdata.txt" );
  code = $fscanf( fd, "%s", tok );
  while( code == 1 )
    begin
      if( tok[7 : 0] == "#" )
        code = $fgets( note, fd );
      else if( tok == "pkt" )
        begin
          code = $fscanf( fd, "%d %h %h %d %d %h", n_words, hdr24, flip, err, corr, residual );
          if( code != 6 )
            abort_run( "malformed packet record in the test data" );
          clean = { 2'b00, header_ecc( hdr24 ), hdr24 };
          push_word( clean ^ flip, n_words == 0 );
          exp_q.push_back( exp_word_t'{ clean ^ residual, n_words == 0, 1'b1, err, corr } );
          for( int w = 0; w < n_words; w++ )
            begin
              code = $fscanf( fd, "%h %h %h %h", b[0], b[1], b[2], b[3] );
              if( code != 4 )
                abort_run( "malformed payload word in the test data" );
              push_word( { b[3], b[2], b[1], b[0] }, w == n_words - 1 );
              exp_q.push_back( exp_word_t'{ { b[3], b[2], b[1], b[0] }, w == n_words - 1,
                                            1'b0, 1'b0, 1'b0 } );
            end
        end
      else
        abort_run( "unknown record in the test data" );
      code = $fscanf( fd, "%s", tok );
    end
  $fclose( fd );
  if( exp_q.size() == 0 )
    abort_run( "test data holds no packets" );
  // Same packets again, under other random timing
  n_bytes = byte_q.size();
  n_exp   = exp_q.size();
  for( int p = 1; p < PASSES; p++ )
    begin
      for( int i = 0; i < n_bytes; i++ )
        byte_q.push_back( byte_q[i] );
      for( int i = 0; i < n_exp; i++ )
        exp_q.push_back( exp_q[i] );
    end
endtask

//////////////////////////////
// Stimulus and checks
//////////////////////////////

task automatic drive_stream();
  int idx;
  int rnd;
  int stall_left;
  int blocked;
  int cycles;
  idx        = 0;
  stall_left = 0;
  blocked    = 0;
  cycles     = 0;
  while( !rx_done )
    begin
      @( posedge clk_i );
      cycles++;
      if( cycles > RUN_LIMIT )
        abort_run( "run did not finish within the cycle limit" );
      rnd = $random( seed );
      // Short random gaps, now and then a stall long enough to fill the FIFO
      if( stall_left > 0 )
        begin
          stall_left--;
          word_ready_i <= 1'b0;
        end
      else if( rnd[8 : 4] == 5'd0 )
        begin
          stall_left = LONG_STALL;
          word_ready_i <= 1'b0;
        end
      else
        word_ready_i <= ( rnd[1 : 0] != 2'b00 );
      if( byte_valid_i && !byte_ready_o )
        begin
          blocked++;
          if( blocked >= 3 )
            fill_seen = 1'b1;
          if( blocked > BYTE_LIMIT )
            abort_run( "byte input stalled for too long" );
        end
      else
        begin
          if( byte_valid_i )
            idx++;
          blocked = 0;
          if( idx < byte_q.size() && rnd[3 : 2] != 2'b00 )
            begin
              byte_valid_i <= 1'b1;
              byte_i       <= byte_q[idx].data;
              byte_last_i  <= byte_q[idx].last;
            end
          else
            byte_valid_i <= 1'b0;
        end
    end
  word_ready_i <= 1'b1;
endtask

task automatic check_stream();
  exp_word_t ew;
  int        cycles;
  logic      taken;
  foreach( exp_q[i] )
    begin
      ew     = exp_q[i];
      taken  = 1'b0;
      cycles = 0;
      while( !taken )
        begin
          @( posedge clk_i );
          taken = word_valid_o && word_ready_i;
          cycles++;
          if( !taken && cycles > WORD_LIMIT )
            abort_run( "no output word arrived within the timeout" );
        end
      check_word( "word_o", word_o, ew.word );
      check_flag( "word_last_o", word_last_o, ew.last );
      check_flag( "hdr_o", hdr_o, ew.hdr );
      if( ew.hdr )
        begin
          check_flag( "hdr_error_o", hdr_error_o, ew.err );
          check_flag( "hdr_corrected_o", hdr_corrected_o, ew.corr );
        end
    end
  cycles = 0;
  while( cycles < 50 )
    begin
      @( posedge clk_i );
      if( word_valid_o )
        abort_run( "output word beyond the expected stream" );
      cycles++;
    end
  rx_done = 1'b1;
endtask

initial
  begin
    srst_i       = 1'b1;
    byte_valid_i = 1'b0;
    byte_i       = '0;
    byte_last_i  = 1'b0;
    word_ready_i = 1'b0;
    rx_done      = 1'b0;
    fill_seen    = 1'b0;
    load_testdata();
    repeat( 10 ) @( posedge clk_i );
    srst_i <= 1'b0;
    fork
      drive_stream();
      check_stream();
    join
    if( !fill_seen )
      abort_run( "FIFO never filled under back-pressure" );
    else
      begin
        $display( "sim passed" );
        $finish;
      end
  end

endmodule

//--- sim/csi2_testdata.txt
# pkt <payload words> <header 23..0> <flip 31..0> <err> <corr> <residual 31..0>
# then one line per payload word, four hex bytes in lane order
pkt 2 00402B 00000000 0 0 00000000
11 22 33 44
55 66 77 88
pkt 0 0A0112 00000000 0 0 00000000
pkt 1 00802B 00000001 1 1 00000000
DE AD BE EF
pkt 0 00402B 00800000 1 1 00000000
pkt 1 123456 00001000 1 1 00000000
00 00 00 00
pkt 0 00402B 00000003 1 0 00000003
pkt 0 ABCDEF 00020020 1 0 00020020
pkt 1 00402B 01000000 1 0 01000000
FF FF FF FF
pkt 0 00402B 20000000 1 0 20000000
pkt 0 0F0F0F 04000008 1 0 04000008
pkt 0 00402B 00000013 1 1 00100013
pkt 0 3C3C3C C0000000 0 0 C0000000
pkt 3 00402B 00000000 0 0 00000000
01 00 00 00
2B 40 00 3F
2B 40 00 00
pkt 2 F0F0F0 00000200 1 1 00000000
A5 5A A5 5A
12 34 56 78

//--- build.f
+incdir+verilog
verilog/csi2_types_pkg.sv
verilog/csi2_ecc_pkg.sv
verilog/csi2_word_if.sv
verilog/csi2_byte_packer.sv
verilog/csi2_word_fifo.sv
verilog/csi2_syndrome_rom.sv
verilog/csi2_header_dec.sv
verilog/csi2_header_rx.sv
sim/tb_clock_gen.sv
sim/tb_csi2_header_rx.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_csi2_header_rx
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) sim/csi2_testdata.txt
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
